// File: vlog.f
+incdir+sim
source/mem_pkg.sv
source/mem_stage.sv
source/data_ram.sv
source/reg_file.sv
source/mem_subsys.sv
sim/mem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= mem_subsys_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

# the run status is ignored, the log decides pass or fail.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// compare one value and stop on the first mismatch.
`define CHECK_VAL(label, act, exp_v) \
	assert ((act) === (exp_v)) else begin \
		$display("ERR %0t %s: is %h, should be %h", $time, label, act, exp_v); \
		stop_run(); \
	end

logic [31:0] lfsr_state = 32'hb2b5_4ca5;
logic [7:0] ram_bytes [4 * RAM_WORDS];	// byte image of the data RAM.
logic [31:0] reg_model [16];

// taps for x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one shift per bit taken.
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

function automatic int width_bytes(input mem_width_t w);
	case (w)
	MEM_BYTE: return 1;
	MEM_HALF: return 2;
	default: return 4;	// spare code is a word.
	endcase
endfunction

function automatic logic [31:0] align_addr(input logic [31:0] a, input mem_width_t w);
	return a & ~(32'(width_bytes(w)) - 32'd1);
endfunction

function automatic logic in_range(input logic [31:0] a);
	return a < 32'(4 * RAM_WORDS);
endfunction

// little-endian lanes, low byte of the value at the lowest address.
function automatic void model_write(input logic [31:0] a, input mem_width_t w,
		input logic [31:0] d);
	logic [9:0] base;
	if (in_range(a)) begin
		base = 10'(align_addr(a, w));
		for (int i = 0; i < width_bytes(w); i++)
			ram_bytes[base + 10'(i)] = 8'(d >> (8 * i));
	end
endfunction

function automatic logic [31:0] model_read(input logic [31:0] a, input mem_width_t w);
	logic [9:0] base;
	logic [31:0] v;
	base = 10'(align_addr(a, w));
	v = '0;
	for (int i = 0; i < width_bytes(w); i++)
		v = v | (32'(ram_bytes[base + 10'(i)]) << (8 * i));
	return v;
endfunction

`endif

// File: sim/mem_subsys_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb import mem_pkg::*; ();

	localparam int RAM_WORDS = 256;
	localparam int CLK_PERIOD = 40;
	localparam int RANDOM_OPS = 200;
	localparam int TEST_CYCLES = 3 * RAM_WORDS + 3 * RANDOM_OPS + 400;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

	logic clk;
	logic rst;
	logic load;
	logic store;
	logic [31:0] addr;
	logic [31:0] mdr;
	logic mem_wr_en;
	mem_width_t width;
	logic [31:0] wr_val;
	logic update_rd;
	logic [3:0] rd_sel;
	logic dbg_en;
	logic dbg_access;
	logic dbg_wr_en;
	logic [31:0] dbg_addr;
	mem_width_t dbg_width;
	logic [31:0] dbg_wr_val;
	logic [3:0] rs_sel;
	logic complete;
	logic data_abort;
	logic [31:0] dbg_rd_val;
	logic dbg_compl;
	logic [31:0] rs_val;
	logic bus_strobe;

	`include "tb_util.svh"

	mem_subsys #(
		.RAM_WORDS	(RAM_WORDS)
	) dut_i (
		.clk(clk), .rst(rst), .load(load), .store(store), .addr(addr), .mdr(mdr),
		.mem_wr_en(mem_wr_en), .width(width), .wr_val(wr_val), .update_rd(update_rd),
		.rd_sel(rd_sel), .dbg_en(dbg_en), .dbg_access(dbg_access), .dbg_wr_en(dbg_wr_en),
		.dbg_addr(dbg_addr), .dbg_width(dbg_width), .dbg_wr_val(dbg_wr_val),
		.rs_sel(rs_sel), .complete(complete), .data_abort(data_abort),
		.dbg_rd_val(dbg_rd_val), .dbg_compl(dbg_compl), .rs_val(rs_val)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	assign bus_strobe = dbg_en ? dbg_access : (load | store);

	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "run stopped at first failure");
	endtask

	// the bus answers every strobe exactly one cycle later and only then.
	strobe_then_complete: assert property (@(posedge clk) disable iff (rst)
		bus_strobe |=> complete) else begin
		$display("complete did not follow a bus strobe by one cycle");
		stop_run();
	end
	idle_then_quiet: assert property (@(posedge clk) disable iff (rst)
		!bus_strobe |=> !complete) else begin
		$display("complete came without a bus strobe");
		stop_run();
	end
	abort_is_complete: assert property (@(posedge clk) disable iff (rst)
		data_abort |-> complete) else begin
		$display("data_abort was high outside a completion cycle");
		stop_run();
	end

	// pulse a load or store and check completion and the destination register.
	task automatic mem_access(input logic is_load, input logic [31:0] a,
			input mem_width_t w, input logic [31:0] d, input logic [3:0] rd);
		@(negedge clk);
		load = is_load;
		store = ~is_load;
		mem_wr_en = ~is_load;
		addr = a;
		width = w;
		mdr = d;
		rd_sel = rd;
		rs_sel = rd;
		@(negedge clk);
		load = 1'b0;
		store = 1'b0;
		`CHECK_VAL("complete", complete, 1'b1)
		`CHECK_VAL("data_abort", data_abort, ~in_range(a))
		if (!is_load)
			model_write(a, w, d);
		else if (in_range(a))
			reg_model[rd] = model_read(a, w);
		@(negedge clk);
		mem_wr_en = 1'b0;
		`CHECK_VAL("rs_val", rs_val, reg_model[rd])
	endtask

	task automatic bypass_write(input logic [3:0] rd, input logic [31:0] v);
		@(negedge clk);
		update_rd = 1'b1;
		rd_sel = rd;
		wr_val = v;
		rs_sel = rd;
		@(negedge clk);
		update_rd = 1'b0;
		reg_model[rd] = v;
		@(negedge clk);
		`CHECK_VAL("rs_val", rs_val, reg_model[rd])
	endtask

	task automatic debug_access(input logic is_write, input logic [31:0] a,
			input mem_width_t w, input logic [31:0] d);
		@(negedge clk);
		dbg_en = 1'b1;
		dbg_access = 1'b1;
		dbg_wr_en = is_write;
		dbg_addr = a;
		dbg_width = w;
		dbg_wr_val = d;
		@(negedge clk);
		dbg_access = 1'b0;
		`CHECK_VAL("dbg_compl", dbg_compl, 1'b1)
		`CHECK_VAL("data_abort", data_abort, ~in_range(a))
		if (is_write) begin
			model_write(a, w, d);
		end else if (in_range(a)) begin
			`CHECK_VAL("dbg_rd_val", dbg_rd_val, model_read(a, w))
		end
		@(negedge clk);
		dbg_en = 1'b0;
		dbg_wr_en = 1'b0;
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			rs_sel = 4'(i);
			@(negedge clk);
			`CHECK_VAL("rs_val", rs_val, reg_model[4'(i)])
		end
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		stop_run();
	end

	initial begin
		logic [31:0] a;
		logic [31:0] d;
		logic [1:0] op;
		logic [1:0] wcode;
		logic [3:0] rd;
		mem_width_t w;
		clk = 1'b0;
		rst = 1'b1;
		load = 1'b0;
		store = 1'b0;
		addr = '0;
		mdr = '0;
		mem_wr_en = 1'b0;
		width = MEM_WORD;
		wr_val = '0;
		update_rd = 1'b0;
		rd_sel = '0;
		dbg_en = 1'b0;
		dbg_access = 1'b0;
		dbg_wr_en = 1'b0;
		dbg_addr = '0;
		dbg_width = MEM_WORD;
		dbg_wr_val = '0;
		rs_sel = '0;
		for (int i = 0; i < 16; i++)
			reg_model[i] = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		// known contents in every word.
		for (int i = 0; i < RAM_WORDS; i++) begin
			a = 32'(4 * i);
			mem_access(1'b0, a, MEM_WORD, (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f, 4'd0);
		end

		mem_access(1'b0, 32'h0000_0040, MEM_WORD, 32'hdead_beef, 4'd3);
		mem_access(1'b1, 32'h0000_0040, MEM_WORD, 32'h0, 4'd3);

		// byte lanes and half lanes read back as words and as themselves.
		for (int off = 0; off < 4; off++)
			mem_access(1'b0, 32'h80 + 32'(off), MEM_BYTE, rand_bits(32), 4'd4);
		mem_access(1'b1, 32'h0000_0080, MEM_WORD, 32'h0, 4'd4);
		for (int off = 0; off < 4; off++) begin
			mem_access(1'b0, 32'h84 + 32'(off), MEM_BYTE, rand_bits(32), 4'd5);
			mem_access(1'b1, 32'h0000_0084, MEM_WORD, 32'h0, 4'd5);
			mem_access(1'b1, 32'h84 + 32'(off), MEM_BYTE, 32'h0, 4'd6);
		end
		for (int off = 0; off < 4; off += 2) begin
			mem_access(1'b0, 32'h88 + 32'(off), MEM_HALF, rand_bits(32), 4'd7);
			mem_access(1'b1, 32'h0000_0088, MEM_WORD, 32'h0, 4'd7);
			mem_access(1'b1, 32'h88 + 32'(off), MEM_HALF, 32'h0, 4'd8);
		end

		bypass_write(4'd1, 32'h1234_5678);
		bypass_write(4'd2, 32'hcafe_f00d);
		bypass_write(4'd15, 32'h8000_0001);
		mem_access(1'b0, 32'h0000_0090, MEM_WORD, 32'h0bad_c0de, 4'd1);
		mem_access(1'b0, 32'h0000_0095, MEM_BYTE, 32'h0000_00aa, 4'd15);
		check_all_regs();

		// accesses past the depth including one that would alias to 0x80.
		mem_access(1'b1, 32'h0000_0400, MEM_WORD, 32'h0, 4'd3);
		mem_access(1'b0, 32'h0000_0480, MEM_WORD, 32'hffff_ffff, 4'd3);
		mem_access(1'b0, 32'hffff_fffc, MEM_HALF, 32'h0000_5555, 4'd3);
		mem_access(1'b1, 32'h0000_0080, MEM_WORD, 32'h0, 4'd9);

		debug_access(1'b1, 32'h0000_00a1, MEM_BYTE, 32'hffff_ff3c);
		debug_access(1'b1, 32'h0000_00a6, MEM_HALF, 32'h1111_beef);
		debug_access(1'b1, 32'h0000_00a8, MEM_WORD, 32'h7654_3210);
		debug_access(1'b0, 32'h0000_00a0, MEM_WORD, 32'h0);
		debug_access(1'b0, 32'h0000_00a4, MEM_WORD, 32'h0);
		debug_access(1'b0, 32'h0000_00a1, MEM_BYTE, 32'h0);
		debug_access(1'b0, 32'h0000_00a6, MEM_HALF, 32'h0);
		debug_access(1'b0, 32'h0000_00a8, MEM_WORD, 32'h0);
		debug_access(1'b0, 32'h0000_0800, MEM_WORD, 32'h0);
		check_all_regs();

		for (int n = 0; n < RANDOM_OPS; n++) begin
			op = 2'(rand_bits(2));
			wcode = 2'(rand_bits(2));
			w = mem_width_t'(wcode);
			if (rand_bits(3) == 32'd0)
				a = (rand_bits(30) << 2) | 32'h0000_0400;	// always past the depth.
			else
				a = rand_bits(10);
			a = align_addr(a, w);
			d = rand_bits(32);
			rd = 4'(rand_bits(4));
			case (op)
			2'd1: mem_access(1'b0, a, w, d, rd);
			2'd2: bypass_write(rd, d);
			default: mem_access(1'b1, a, w, d, rd);
			endcase
		end
		check_all_regs();

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys import mem_pkg::*; #(
	parameter int RAM_WORDS = 256
) (
	input wire		clk,
	input wire		rst,
	// pipeline side.
	input wire		load,
	input wire		store,
	input wire [31:0]	addr,
	input wire [31:0]	mdr,
	input wire		mem_wr_en,
	input wire mem_width_t	width,
	input wire [31:0]	wr_val,
	input wire		update_rd,
	input wire [3:0]	rd_sel,
	// debug side.
	input wire		dbg_en,
	input wire		dbg_access,
	input wire		dbg_wr_en,
	input wire [31:0]	dbg_addr,
	input wire mem_width_t	dbg_width,
	input wire [31:0]	dbg_wr_val,
	// register read port.
	input wire [3:0]	rs_sel,
	output logic		complete,
	output logic		data_abort,
	output logic [31:0]	dbg_rd_val,
	output logic		dbg_compl,
	output logic [31:0]	rs_val
);

	dbus_req_t req;
	dbus_rsp_t rsp;
	wb_t wb;

	mem_stage mem_stage_i (
		.clk		(clk),
		.rst		(rst),
		.load		(load),
		.store		(store),
		.addr		(addr),
		.mdr		(mdr),
		.mem_wr_en	(mem_wr_en),
		.width		(width),
		.wr_val		(wr_val),
		.update_rd	(update_rd),
		.rd_sel		(rd_sel),
		.dbg_en		(dbg_en),
		.dbg_access	(dbg_access),
		.dbg_wr_en	(dbg_wr_en),
		.dbg_addr	(dbg_addr),
		.dbg_width	(dbg_width),
		.dbg_wr_val	(dbg_wr_val),
		.rsp		(rsp),
		.req		(req),
		.wb		(wb),
		.complete	(complete),
		.data_abort	(data_abort),
		.dbg_rd_val	(dbg_rd_val),
		.dbg_compl	(dbg_compl)
	);

	// the only target on the data bus.
	data_ram #(
		.RAM_WORDS	(RAM_WORDS)
	) data_ram_i (
		.clk		(clk),
		.rst		(rst),
		.req		(req),
		.rsp		(rsp)
	);

	reg_file reg_file_i (
		.clk		(clk),
		.rst		(rst),
		.wb		(wb),
		.rs_sel		(rs_sel),
		.rs_val		(rs_val)
	);

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import mem_pkg::*; (
	input wire		clk,
	input wire		rst,
	input wire wb_t		wb,
	input wire [3:0]	rs_sel,
	output logic [31:0]	rs_val
);

	logic [31:0] regs [16];

	// one write port fed by the writeback bundle.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wb.update) begin
			regs[wb.sel] <= wb.val;
		end
	end

	assign rs_val = regs[rs_sel];	// no write-through.

endmodule

`default_nettype wire

// File: source/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram import mem_pkg::*; #(
	parameter int RAM_WORDS = 256
) (
	input wire		clk,
	input wire		rst,
	input wire dbus_req_t	req,
	output dbus_rsp_t	rsp
);

	localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	logic [31:0] mem [RAM_WORDS];
	logic [IDX_W-1:0] idx;
	logic in_range;
	logic [31:0] rd_word;
	logic ack_q;
	logic err_q;

	// anything at or past the depth is a bus error.
	assign in_range = req.addr < 30'(RAM_WORDS);
	assign idx = req.addr[IDX_W-1:0];

	// storage and registered read.
	always_ff @(posedge clk) begin
		if (req.access && in_range) begin
			if (req.wr_en) begin
				for (int i = 0; i < 4; i++) begin
					if (req.bytesel[i])
						mem[idx][i*8 +: 8] <= req.wr_val[i*8 +: 8];
				end
			end
			rd_word <= mem[idx];	// old word on a store.
		end
	end

	// exactly one of ack or error, one cycle after the strobe.
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= req.access & in_range;
			err_q <= req.access & ~in_range;
		end
	end

	always_comb begin
		rsp.data = rd_word;
		rsp.ack = ack_q;
		rsp.error = err_q;
	end

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage import mem_pkg::*; (
	input wire		clk,
	input wire		rst,
	// pipeline side.
	input wire		load,
	input wire		store,
	input wire [31:0]	addr,
	input wire [31:0]	mdr,
	input wire		mem_wr_en,
	input wire mem_width_t	width,
	input wire [31:0]	wr_val,
	input wire		update_rd,
	input wire [3:0]	rd_sel,
	// debug side.
	input wire		dbg_en,
	input wire		dbg_access,
	input wire		dbg_wr_en,
	input wire [31:0]	dbg_addr,
	input wire mem_width_t	dbg_width,
	input wire [31:0]	dbg_wr_val,
	// data bus.
	input wire dbus_rsp_t	rsp,
	output dbus_req_t	req,
	// writeback and status.
	output wb_t		wb,
	output logic		complete,
	output logic		data_abort,
	output logic [31:0]	dbg_rd_val,
	output logic		dbg_compl
);

	logic [31:0] acc_addr;
	logic [31:0] acc_data;
	mem_width_t acc_width;
	logic [1:0] byte_off;
	logic [3:0] bytesel;
	logic [31:0] lane_data;
	logic [31:0] rd_aligned;

	logic bypass_update;
	logic [3:0] bypass_sel;
	logic [31:0] bypass_val;

	logic mem_live;		// a pipeline access is completing this cycle.
	logic mem_is_load;
	logic [3:0] mem_rd;
	logic mem_wb;

	// debug takes the whole bus while it is enabled.
	assign acc_addr = dbg_en ? dbg_addr : addr;
	assign acc_data = dbg_en ? dbg_wr_val : mdr;
	assign acc_width = dbg_en ? dbg_width : width;
	assign byte_off = acc_addr[1:0];

	// lane steering on the way out and alignment on the way back.
	always_comb begin
		case (acc_width)
		MEM_BYTE: begin
			bytesel = 4'b0001 << byte_off;
			lane_data = acc_data << {byte_off, 3'b000};
			rd_aligned = (rsp.data >> {byte_off, 3'b000}) & 32'h0000_00ff;
		end
		MEM_HALF: begin
			bytesel = 4'b0011 << {byte_off[1], 1'b0};
			lane_data = acc_data << {byte_off[1], 4'b0000};
			rd_aligned = (rsp.data >> {byte_off[1], 4'b0000}) & 32'h0000_ffff;
		end
		default: begin
			bytesel = 4'b1111;
			lane_data = acc_data;
			rd_aligned = rsp.data;
		end
		endcase
	end

	always_comb begin
		req.addr = acc_addr[31:2];
		req.bytesel = bytesel;
		req.wr_en = dbg_en ? dbg_wr_en : mem_wr_en;
		req.wr_val = lane_data;
		req.access = dbg_en ? dbg_access : (load | store);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bypass_update <= 1'b0;
			mem_live <= 1'b0;
			mem_is_load <= 1'b0;
		end else begin
			bypass_update <= update_rd;
			mem_live <= (load | store) & ~dbg_en;	// debug never writes back.
			if (load | store)
				mem_is_load <= load;
		end
	end

	always_ff @(posedge clk) begin
		bypass_val <= wr_val;
		bypass_sel <= rd_sel;
		if (load)
			mem_rd <= rd_sel;	// destination held until completion.
	end

	assign complete = rsp.ack | rsp.error;
	assign data_abort = rsp.error;
	assign mem_wb = complete & mem_live;

	// a completing pipeline access owns the writeback port.
	always_comb begin
		wb.update = mem_wb ? (mem_is_load & rsp.ack) : bypass_update;
		wb.sel = mem_wb ? mem_rd : bypass_sel;
		wb.val = mem_wb ? rd_aligned : bypass_val;
	end

	assign dbg_rd_val = rd_aligned;
	assign dbg_compl = complete;

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// access width as carried by the execute stage.
	// the fourth code is not named and the stage reads it as a word.
	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10
	} mem_width_t;

	// request from the memory stage to the data RAM.
	typedef struct packed {
		logic [29:0] addr;	// word address.
		logic [3:0] bytesel;	// one bit per byte lane.
		logic wr_en;
		logic [31:0] wr_val;	// already steered onto its lanes.
		logic access;		// high while a request is live.
	} dbus_req_t;

	// response from the data RAM, one cycle after the request.
	typedef struct packed {
		logic [31:0] data;
		logic ack;
		logic error;		// word address past the RAM depth.
	} dbus_rsp_t;

	// writeback into the register file.
	typedef struct packed {
		logic update;
		logic [3:0] sel;
		logic [31:0] val;
	} wb_t;

endpackage

`default_nettype wire
